// File: common/csr_map_pkg.sv
// csr map package: machine CSR addresses, field masks, reset values and widths
`default_nettype none

package csr_map_pkg;

  localparam int CSR_WIDTH      = 64;
  localparam int CSR_ADDR_WIDTH = 12;

  // floating-point views of the single fcsr register
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_FFLAGS = 12'h001;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_FRM    = 12'h002;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_FCSR   = 12'h003;

  // machine trap setup and handling
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MIE     = 12'h304;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MCAUSE  = 12'h342;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MTVAL   = 12'h343;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MIP     = 12'h344;

  // read-only counters and ids
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MINSTRET = 12'hB02;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MHARTID  = 12'hF14;

  // MIE (bit 3), MPIE (bit 7) and FS (bits 14:13)
  localparam logic [CSR_WIDTH-1:0] MSTATUS_WRITE_MASK = 64'h0000_0000_0000_6088;

  // UXL (33:32) and SXL (35:34) both encode 64-bit
  localparam logic [CSR_WIDTH-1:0] MSTATUS_RESET = 64'h0000_000A_0000_0000;

  localparam int MSTATUS_MIE_BIT = 3;

  // software, timer and external enables for S and M mode
  localparam logic [CSR_WIDTH-1:0] MIE_MASK = 64'h0000_0000_0000_0AAA;

  // only the supervisor pending bits are writable here
  localparam logic [CSR_WIDTH-1:0] MIP_MASK = 64'h0000_0000_0000_0222;

  localparam int FFLAGS_WIDTH = 5;
  localparam int FRM_WIDTH    = 3;

  localparam int CAUSE_WIDTH = 5;

  localparam logic [CAUSE_WIDTH-1:0] CAUSE_MISALIGNED_FETCH = 5'd0;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_FAULT_FETCH      = 5'd1;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_MISALIGNED_LOAD  = 5'd4;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_FAULT_LOAD       = 5'd5;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_MISALIGNED_STORE = 5'd6;
  localparam logic [CAUSE_WIDTH-1:0] CAUSE_FAULT_STORE      = 5'd7;

  // enough for up to 4 retires per cycle
  localparam int COMMIT_CNT_WIDTH = 3;

endpackage

`default_nettype wire

// File: common/csr_types_pkg.sv
// csr types package: request, event and register view structs shared by the CSR blocks
`default_nettype none

package csr_types_pkg;

  import csr_map_pkg::*;

  typedef struct packed {
    logic [CSR_ADDR_WIDTH-1:0] addr;
    logic [CSR_WIDTH-1:0]      data;
  } csr_wr_req_t;

  // load and store addresses feed mtval for the memory causes
  typedef struct packed {
    logic                   valid;
    logic [CAUSE_WIDTH-1:0] cause;
    logic [CSR_WIDTH-1:0]   pc;
    logic [CSR_WIDTH-1:0]   ld_addr;
    logic [CSR_WIDTH-1:0]   st_addr;
  } trap_event_t;

  typedef struct packed {
    logic [COMMIT_CNT_WIDTH-1:0] commit_cnt;
    logic [FFLAGS_WIDTH-1:0]     fflags;
  } retire_info_t;

  // one-hot commit strobes, at most one bit set per cycle
  typedef struct packed {
    logic fflags;
    logic frm;
    logic fcsr;
    logic mstatus;
    logic mie;
    logic mip;
    logic mtvec;
    logic mepc;
    logic mcause;
    logic mtval;
  } csr_wr_sel_t;

  typedef struct packed {
    logic [CSR_WIDTH-1:0] mepc;
    logic [CSR_WIDTH-1:0] mcause;
    logic [CSR_WIDTH-1:0] mtval;
    logic [CSR_WIDTH-1:0] mtvec;
  } trap_view_t;

  typedef struct packed {
    logic [CSR_WIDTH-1:0] mstatus;
    logic [CSR_WIDTH-1:0] mie;
    logic [CSR_WIDTH-1:0] mip;
    logic [CSR_WIDTH-1:0] fcsr;
    logic [CSR_WIDTH-1:0] minstret;
  } mach_view_t;

endpackage

`default_nettype wire

// File: hdl/csr_commit_ctrl.sv
// CSR commit controller: stages a CSR write until commit, drops it on flush, decodes strobes
`default_nettype none

module csr_commit_ctrl
  import csr_map_pkg::*;
  import csr_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush_i,
  input  logic                 commit_i,
  input  logic                 wr_en_i,
  input  csr_wr_req_t          wr_req_i,
  output csr_wr_sel_t          wr_sel_o,
  output logic [CSR_WIDTH-1:0] wr_data_o
);

  csr_wr_req_t staged_req;
  logic        staged_valid;

  // staged payload, only meaningful while staged_valid is set
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      staged_req <= wr_req_i;
    end
  end

  // a new write wins over a flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      staged_valid <= 1'b0;
    end
    else if (wr_en_i)
    begin
      staged_valid <= 1'b1;
    end
    else if (flush_i)
    begin
      staged_valid <= 1'b0;
    end
  end

  // commit leaves staged_valid set, so a repeated commit replays the write
  always_comb
  begin
    wr_sel_o = '0;
    if (commit_i && staged_valid)
    begin
      case (staged_req.addr)
        ADDR_FFLAGS:  wr_sel_o.fflags  = 1'b1;
        ADDR_FRM:     wr_sel_o.frm     = 1'b1;
        ADDR_FCSR:    wr_sel_o.fcsr    = 1'b1;
        ADDR_MSTATUS: wr_sel_o.mstatus = 1'b1;
        ADDR_MIE:     wr_sel_o.mie     = 1'b1;
        ADDR_MIP:     wr_sel_o.mip     = 1'b1;
        ADDR_MTVEC:   wr_sel_o.mtvec   = 1'b1;
        ADDR_MEPC:    wr_sel_o.mepc    = 1'b1;
        ADDR_MCAUSE:  wr_sel_o.mcause  = 1'b1;
        ADDR_MTVAL:   wr_sel_o.mtval   = 1'b1;
        // read-only and unmapped addresses raise no strobe
        default:      wr_sel_o         = '0;
      endcase
    end
  end

  assign wr_data_o = staged_req.data;

endmodule

`default_nettype wire

// File: hdl/csr_file_top.sv
// machine CSR file top: joins commit control, trap and machine registers and the read port
`default_nettype none

module csr_file_top
  import csr_map_pkg::*;
  import csr_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush_i,
  input  logic                      commit_i,
  input  logic                      wr_en_i,
  input  logic                      rd_en_i,
  input  csr_wr_req_t               wr_req_i,
  input  logic [CSR_ADDR_WIDTH-1:0] rd_addr_i,
  input  trap_event_t               trap_i,
  input  retire_info_t              retire_i,
  input  logic [CSR_WIDTH-1:0]      hartid_i,
  output logic [CSR_WIDTH-1:0]      rd_data_o,
  output logic                      atomic_violation_o,
  output logic                      interrupt_pending_o,
  output logic [CSR_WIDTH-1:0]      epc_o,
  output logic [CSR_WIDTH-1:0]      evec_o,
  output logic [CSR_WIDTH-1:0]      status_o,
  output logic [CSR_WIDTH-1:0]      frm_o
);

  csr_wr_sel_t          wr_sel;
  logic [CSR_WIDTH-1:0] wr_data;
  trap_view_t           trap_view;
  mach_view_t           mach_view;

  csr_commit_ctrl csr_commit_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .flush_i   (flush_i),
    .commit_i  (commit_i),
    .wr_en_i   (wr_en_i),
    .wr_req_i  (wr_req_i),
    .wr_sel_o  (wr_sel),
    .wr_data_o (wr_data)
  );

  csr_trap_regs csr_trap_regs_i (
    .clk       (clk),
    .reset     (reset),
    .wr_sel_i  (wr_sel),
    .wr_data_i (wr_data),
    .trap_i    (trap_i),
    .view_o    (trap_view)
  );

  csr_machine_regs csr_machine_regs_i (
    .clk                 (clk),
    .reset               (reset),
    .wr_sel_i            (wr_sel),
    .wr_data_i           (wr_data),
    .retire_i            (retire_i),
    .trap_valid_i        (trap_i.valid),
    .view_o              (mach_view),
    .interrupt_pending_o (interrupt_pending_o)
  );

  csr_read_port csr_read_port_i (
    .clk                (clk),
    .reset              (reset),
    .flush_i            (flush_i),
    .commit_i           (commit_i),
    .rd_en_i            (rd_en_i),
    .rd_addr_i          (rd_addr_i),
    .hartid_i           (hartid_i),
    .trap_view_i        (trap_view),
    .mach_view_i        (mach_view),
    .rd_data_o          (rd_data_o),
    .atomic_violation_o (atomic_violation_o)
  );

  assign epc_o    = trap_view.mepc;
  assign evec_o   = trap_view.mtvec;
  assign status_o = mach_view.mstatus;
  // rounding mode sits above the five flag bits
  assign frm_o    = {{(CSR_WIDTH-FRM_WIDTH){1'b0}},
                     mach_view.fcsr[FFLAGS_WIDTH+FRM_WIDTH-1:FFLAGS_WIDTH]};

endmodule

`default_nettype wire

// File: hdl/csr_machine_regs.sv
// machine state registers: mstatus, mie, mip, fcsr and minstret plus interrupt pending
`default_nettype none

module csr_machine_regs
  import csr_map_pkg::*;
  import csr_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  csr_wr_sel_t          wr_sel_i,
  input  logic [CSR_WIDTH-1:0] wr_data_i,
  input  retire_info_t         retire_i,
  input  logic                 trap_valid_i,
  output mach_view_t           view_o,
  output logic                 interrupt_pending_o
);

  localparam int FCSR_BITS = FFLAGS_WIDTH + FRM_WIDTH;

  logic [CSR_WIDTH-1:0] mstatus_q;
  logic [CSR_WIDTH-1:0] mie_q;
  logic [CSR_WIDTH-1:0] mip_q;
  logic [FCSR_BITS-1:0] fcsr_q;
  logic [CSR_WIDTH-1:0] minstret_q;
  logic [FCSR_BITS-1:0] fcsr_next;
  logic [CSR_WIDTH-1:0] retire_cnt;

  // fcsr holds frm in 7:5 and the sticky flags in 4:0
  always_comb
  begin
    if (wr_sel_i.fcsr)
    begin
      fcsr_next = wr_data_i[FCSR_BITS-1:0];
    end
    else if (wr_sel_i.fflags)
    begin
      fcsr_next = {fcsr_q[FCSR_BITS-1:FFLAGS_WIDTH], wr_data_i[FFLAGS_WIDTH-1:0]};
    end
    else if (wr_sel_i.frm)
    begin
      // flags keep accumulating while only the rounding mode changes
      fcsr_next = {wr_data_i[FRM_WIDTH-1:0],
                   fcsr_q[FFLAGS_WIDTH-1:0] | retire_i.fflags};
    end
    else
    begin
      fcsr_next = {fcsr_q[FCSR_BITS-1:FFLAGS_WIDTH],
                   fcsr_q[FFLAGS_WIDTH-1:0] | retire_i.fflags};
    end
  end

  // each trap counts as one retired instruction
  assign retire_cnt = CSR_WIDTH'(retire_i.commit_cnt) + CSR_WIDTH'(trap_valid_i);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mstatus_q  <= MSTATUS_RESET;
      mie_q      <= '0;
      mip_q      <= '0;
      fcsr_q     <= '0;
      minstret_q <= '0;
    end
    else
    begin
      if (wr_sel_i.mstatus)
      begin
        mstatus_q <= (wr_data_i & MSTATUS_WRITE_MASK) | (mstatus_q & ~MSTATUS_WRITE_MASK);
      end
      if (wr_sel_i.mie)
      begin
        mie_q <= (wr_data_i & MIE_MASK) | (mie_q & ~MIE_MASK);
      end
      if (wr_sel_i.mip)
      begin
        mip_q <= (wr_data_i & MIP_MASK) | (mip_q & ~MIP_MASK);
      end
      fcsr_q     <= fcsr_next;
      minstret_q <= minstret_q + retire_cnt;
    end
  end

  // enabled and pending, gated by the global machine enable
  assign interrupt_pending_o = (|(mie_q & mip_q)) & mstatus_q[MSTATUS_MIE_BIT];

  assign view_o.mstatus  = mstatus_q;
  assign view_o.mie      = mie_q;
  assign view_o.mip      = mip_q;
  assign view_o.fcsr     = {{(CSR_WIDTH-FCSR_BITS){1'b0}}, fcsr_q};
  assign view_o.minstret = minstret_q;

endmodule

`default_nettype wire

// File: hdl/csr_read_port.sv
// CSR read port: combinational read mux with read checkpoint and atomicity-violation check
`default_nettype none

module csr_read_port
  import csr_map_pkg::*;
  import csr_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush_i,
  input  logic                      commit_i,
  input  logic                      rd_en_i,
  input  logic [CSR_ADDR_WIDTH-1:0] rd_addr_i,
  input  logic [CSR_WIDTH-1:0]      hartid_i,
  input  trap_view_t                trap_view_i,
  input  mach_view_t                mach_view_i,
  output logic [CSR_WIDTH-1:0]      rd_data_o,
  output logic                      atomic_violation_o
);

  logic [CSR_ADDR_WIDTH-1:0] chkpt_addr;
  logic [CSR_WIDTH-1:0]      chkpt_data;
  logic                      chkpt_valid;
  logic [CSR_WIDTH-1:0]      chkpt_current;

  // current contents of one CSR, shared by the read and the checkpoint compare
  function automatic logic [CSR_WIDTH-1:0] csr_lookup(
    input logic [CSR_ADDR_WIDTH-1:0] addr,
    input trap_view_t                tv,
    input mach_view_t                mv,
    input logic [CSR_WIDTH-1:0]      hartid
  );
    logic [CSR_WIDTH-1:0] value;
    case (addr)
      ADDR_FFLAGS:   value = {{(CSR_WIDTH-FFLAGS_WIDTH){1'b0}}, mv.fcsr[FFLAGS_WIDTH-1:0]};
      ADDR_FRM:      value = {{(CSR_WIDTH-FRM_WIDTH){1'b0}},
                              mv.fcsr[FFLAGS_WIDTH+FRM_WIDTH-1:FFLAGS_WIDTH]};
      ADDR_FCSR:     value = {{(CSR_WIDTH-FFLAGS_WIDTH-FRM_WIDTH){1'b0}},
                              mv.fcsr[FFLAGS_WIDTH+FRM_WIDTH-1:0]};
      ADDR_MSTATUS:  value = mv.mstatus;
      ADDR_MIE:      value = mv.mie;
      ADDR_MIP:      value = mv.mip;
      ADDR_MTVEC:    value = tv.mtvec;
      ADDR_MEPC:     value = tv.mepc;
      ADDR_MCAUSE:   value = tv.mcause;
      ADDR_MTVAL:    value = tv.mtval;
      ADDR_MINSTRET: value = mv.minstret;
      ADDR_MHARTID:  value = hartid;
      // unmapped addresses read as zero
      default:       value = '0;
    endcase
    return value;
  endfunction

  always_comb
  begin
    rd_data_o     = csr_lookup(rd_addr_i, trap_view_i, mach_view_i, hartid_i);
    chkpt_current = csr_lookup(chkpt_addr, trap_view_i, mach_view_i, hartid_i);
  end

  // address and data of the last read, compared until the reader commits or flushes
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chkpt_addr <= rd_addr_i;
      chkpt_data <= rd_data_o;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chkpt_valid <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chkpt_valid <= 1'b1;
    end
    else if (flush_i || commit_i)
    begin
      chkpt_valid <= 1'b0;
    end
  end

  // the CSR moved after it was read, so the read was not atomic
  assign atomic_violation_o = chkpt_valid && (chkpt_current != chkpt_data);

endmodule

`default_nettype wire

// File: hdl/csr_trap_regs.sv
// trap registers: mepc, mcause, mtval and mtvec, loaded by exceptions and committed writes
`default_nettype none

module csr_trap_regs
  import csr_map_pkg::*;
  import csr_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  csr_wr_sel_t          wr_sel_i,
  input  logic [CSR_WIDTH-1:0] wr_data_i,
  input  trap_event_t          trap_i,
  output trap_view_t           view_o
);

  logic [CSR_WIDTH-1:0] mepc_q;
  logic [CSR_WIDTH-1:0] mcause_q;
  logic [CSR_WIDTH-1:0] mtval_q;
  logic [CSR_WIDTH-1:0] mtvec_q;
  logic [CSR_WIDTH-1:0] mtval_trap;

  // faulting address by cause, other causes keep mtval
  always_comb
  begin
    mtval_trap = mtval_q;
    if (trap_i.valid)
    begin
      case (trap_i.cause)
        CAUSE_MISALIGNED_FETCH, CAUSE_FAULT_FETCH: mtval_trap = trap_i.pc;
        CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD:   mtval_trap = trap_i.ld_addr;
        CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE: mtval_trap = trap_i.st_addr;
        default:                                   mtval_trap = mtval_q;
      endcase
    end
  end

  // a committed write takes priority over a trap in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
      mtvec_q  <= '0;
    end
    else
    begin
      if (wr_sel_i.mepc)
      begin
        // WARL: instructions are at least 2-byte aligned
        mepc_q <= {wr_data_i[CSR_WIDTH-1:1], 1'b0};
      end
      else if (trap_i.valid)
      begin
        mepc_q <= trap_i.pc;
      end

      if (wr_sel_i.mcause)
      begin
        mcause_q <= wr_data_i;
      end
      else if (trap_i.valid)
      begin
        mcause_q <= {{(CSR_WIDTH-CAUSE_WIDTH){1'b0}}, trap_i.cause};
      end

      mtval_q <= wr_sel_i.mtval ? wr_data_i : mtval_trap;

      if (wr_sel_i.mtvec)
      begin
        // mode bit 1 is reserved, only direct and vectored remain
        mtvec_q <= {wr_data_i[CSR_WIDTH-1:2], 1'b0, wr_data_i[0]};
      end
    end
  end

  assign view_o.mepc   = mepc_q;
  assign view_o.mcause = mcause_q;
  assign view_o.mtval  = mtval_q;
  assign view_o.mtvec  = mtvec_q;

endmodule

`default_nettype wire

// File: sources.f
+incdir+verification
common/csr_map_pkg.sv
common/csr_types_pkg.sv
hdl/csr_commit_ctrl.sv
hdl/csr_trap_regs.sv
hdl/csr_machine_regs.sv
hdl/csr_read_port.sv
hdl/csr_file_top.sv
verification/csr_file_tb.sv

// File: verification/csr_file_model.svh
// CSR file reference model: expected register state, write staging and read checkpoint
`ifndef CSR_FILE_MODEL_SVH
`define CSR_FILE_MODEL_SVH

logic [CSR_WIDTH-1:0]      m_mstatus;
logic [CSR_WIDTH-1:0]      m_mie;
logic [CSR_WIDTH-1:0]      m_mip;
logic [CSR_WIDTH-1:0]      m_mtvec;
logic [CSR_WIDTH-1:0]      m_mepc;
logic [CSR_WIDTH-1:0]      m_mcause;
logic [CSR_WIDTH-1:0]      m_mtval;
logic [CSR_WIDTH-1:0]      m_minstret;
logic [7:0]                m_fcsr;
logic                      stg_valid;
logic [CSR_ADDR_WIDTH-1:0] stg_addr;
logic [CSR_WIDTH-1:0]      stg_data;
logic                      chk_valid;
logic [CSR_ADDR_WIDTH-1:0] chk_addr;
logic [CSR_WIDTH-1:0]      chk_data;

// expected read value of one CSR from the model state
function automatic logic [CSR_WIDTH-1:0] expected_csr(input logic [CSR_ADDR_WIDTH-1:0] addr);
  logic [CSR_WIDTH-1:0] value;
  case (addr)
    ADDR_FFLAGS:   value = CSR_WIDTH'(m_fcsr[4:0]);
    ADDR_FRM:      value = CSR_WIDTH'(m_fcsr[7:5]);
    ADDR_FCSR:     value = CSR_WIDTH'(m_fcsr);
    ADDR_MSTATUS:  value = m_mstatus;
    ADDR_MIE:      value = m_mie;
    ADDR_MIP:      value = m_mip;
    ADDR_MTVEC:    value = m_mtvec;
    ADDR_MEPC:     value = m_mepc;
    ADDR_MCAUSE:   value = m_mcause;
    ADDR_MTVAL:    value = m_mtval;
    ADDR_MINSTRET: value = m_minstret;
    ADDR_MHARTID:  value = hartid_i;
    default:       value = '0;
  endcase
  return value;
endfunction

function automatic logic expected_violation();
  return chk_valid && (expected_csr(chk_addr) != chk_data);
endfunction

task automatic model_reset();
  m_mstatus  = MSTATUS_RESET;
  m_mie      = '0;
  m_mip      = '0;
  m_mtvec    = '0;
  m_mepc     = '0;
  m_mcause   = '0;
  m_mtval    = '0;
  m_minstret = '0;
  m_fcsr     = '0;
  stg_valid  = 1'b0;
  chk_valid  = 1'b0;
endtask

// advance the model by one clock edge with the inputs the DUT sees at that edge
task automatic model_step();
  logic commit_now;
  logic flags_written;
  commit_now    = commit_i && stg_valid;
  flags_written = 1'b0;

  // the checkpoint sees the value from before this edge
  if (rd_en_i)
  begin
    chk_valid = 1'b1;
    chk_addr  = rd_addr_i;
    chk_data  = expected_csr(rd_addr_i);
  end
  else if (flush_i || commit_i)
  begin
    chk_valid = 1'b0;
  end

  if (trap_i.valid)
  begin
    m_mepc   = trap_i.pc;
    m_mcause = CSR_WIDTH'(trap_i.cause);
    case (trap_i.cause)
      CAUSE_MISALIGNED_FETCH, CAUSE_FAULT_FETCH: m_mtval = trap_i.pc;
      CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD:   m_mtval = trap_i.ld_addr;
      CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE: m_mtval = trap_i.st_addr;
      default:                                   m_mtval = m_mtval;
    endcase
  end

  // committed writes come after the trap so they win
  if (commit_now)
  begin
    case (stg_addr)
      ADDR_MSTATUS: m_mstatus = (m_mstatus & ~MSTATUS_WRITE_MASK) | (stg_data & MSTATUS_WRITE_MASK);
      ADDR_MIE:     m_mie = (m_mie & ~MIE_MASK) | (stg_data & MIE_MASK);
      ADDR_MIP:     m_mip = (m_mip & ~MIP_MASK) | (stg_data & MIP_MASK);
      ADDR_MTVEC:   m_mtvec = stg_data & ~CSR_WIDTH'(2);
      ADDR_MEPC:    m_mepc = stg_data & ~CSR_WIDTH'(1);
      ADDR_MCAUSE:  m_mcause = stg_data;
      ADDR_MTVAL:   m_mtval = stg_data;
      ADDR_FRM:     m_fcsr[7:5] = stg_data[2:0];
      ADDR_FFLAGS:
      begin
        m_fcsr[4:0]   = stg_data[4:0];
        flags_written = 1'b1;
      end
      ADDR_FCSR:
      begin
        m_fcsr        = stg_data[7:0];
        flags_written = 1'b1;
      end
      default:      m_fcsr = m_fcsr;
    endcase
  end

  if (!flags_written)
  begin
    m_fcsr[4:0] = m_fcsr[4:0] | retire_i.fflags;
  end
  m_minstret = m_minstret + CSR_WIDTH'(retire_i.commit_cnt) + CSR_WIDTH'(trap_i.valid);

  if (wr_en_i)
  begin
    stg_valid = 1'b1;
    stg_addr  = wr_req_i.addr;
    stg_data  = wr_req_i.data;
  end
  else if (flush_i)
  begin
    stg_valid = 1'b0;
  end
endtask

`endif

// File: verification/csr_file_tb.sv
// CSR file testbench: directed and random stimulus checked against a reference model
`default_nettype none

module csr_file_tb
  import csr_map_pkg::*;
  import csr_types_pkg::*;
();

  localparam int DIRECTED_OPS    = 80;
  localparam int RANDOM_OPS      = 150;
  localparam int NUM_OPS         = DIRECTED_OPS + RANDOM_OPS;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 6 + 50;

  logic                      clk;
  logic                      reset;
  logic                      flush_i;
  logic                      commit_i;
  logic                      wr_en_i;
  logic                      rd_en_i;
  csr_wr_req_t               wr_req_i;
  logic [CSR_ADDR_WIDTH-1:0] rd_addr_i;
  trap_event_t               trap_i;
  retire_info_t              retire_i;
  logic [CSR_WIDTH-1:0]      hartid_i;
  logic [CSR_WIDTH-1:0]      rd_data_o;
  logic                      atomic_violation_o;
  logic                      interrupt_pending_o;
  logic [CSR_WIDTH-1:0]      epc_o;
  logic [CSR_WIDTH-1:0]      evec_o;
  logic [CSR_WIDTH-1:0]      status_o;
  logic [CSR_WIDTH-1:0]      frm_o;

  integer seed        = 58;
  int     check_count = 0;
  int     error_count = 0;
  logic   fp_random   = 1'b0;

  `include "csr_file_model.svh"

  csr_file_top csr_file_top_i (
    .clk                 (clk),
    .reset               (reset),
    .flush_i             (flush_i),
    .commit_i            (commit_i),
    .wr_en_i             (wr_en_i),
    .rd_en_i             (rd_en_i),
    .wr_req_i            (wr_req_i),
    .rd_addr_i           (rd_addr_i),
    .trap_i              (trap_i),
    .retire_i            (retire_i),
    .hartid_i            (hartid_i),
    .rd_data_o           (rd_data_o),
    .atomic_violation_o  (atomic_violation_o),
    .interrupt_pending_o (interrupt_pending_o),
    .epc_o               (epc_o),
    .evec_o              (evec_o),
    .status_o            (status_o),
    .frm_o               (frm_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (reset)
    begin
      model_reset();
    end
    else
    begin
      model_step();
    end
  end

  task automatic check_value(input string name, input logic [CSR_WIDTH-1:0] expected,
                             input logic [CSR_WIDTH-1:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      check_value("rd_data_o", expected_csr(rd_addr_i), rd_data_o);
      check_value("atomic_violation_o", CSR_WIDTH'(expected_violation()),
                  CSR_WIDTH'(atomic_violation_o));
      check_value("interrupt_pending_o", CSR_WIDTH'((|(m_mie & m_mip)) & m_mstatus[3]),
                  CSR_WIDTH'(interrupt_pending_o));
      check_value("epc_o", m_mepc, epc_o);
      check_value("evec_o", m_mtvec, evec_o);
      check_value("status_o", m_mstatus, status_o);
      check_value("frm_o", CSR_WIDTH'(m_fcsr[7:5]), frm_o);
    end
  end

  // one clock edge with idle strobes and a random retire count
  task automatic step();
    logic [31:0] flags;
    flags = $random(seed);
    @(posedge clk);
    wr_en_i             <= 1'b0;
    commit_i            <= 1'b0;
    flush_i             <= 1'b0;
    rd_en_i             <= 1'b0;
    trap_i              <= '0;
    retire_i.commit_cnt <= COMMIT_CNT_WIDTH'($unsigned($random(seed)) % 5);
    retire_i.fflags     <= (fp_random && flags[7:5] == 3'd0) ? flags[4:0] : 5'd0;
  endtask

  task automatic stage_write(input logic [CSR_ADDR_WIDTH-1:0] addr,
                             input logic [CSR_WIDTH-1:0] data);
    step();
    wr_en_i  <= 1'b1;
    wr_req_i <= {addr, data};
  endtask

  task automatic commit_only(input logic with_read);
    step();
    commit_i <= 1'b1;
    rd_en_i  <= with_read;
  endtask

  task automatic flush_only();
    step();
    flush_i <= 1'b1;
  endtask

  task automatic write_commit(input logic [CSR_ADDR_WIDTH-1:0] addr,
                              input logic [CSR_WIDTH-1:0] data);
    stage_write(addr, data);
    commit_only(1'b0);
  endtask

  task automatic write_flush_commit(input logic [CSR_ADDR_WIDTH-1:0] addr,
                                    input logic [CSR_WIDTH-1:0] data);
    stage_write(addr, data);
    flush_only();
    commit_only(1'b0);
  endtask

  task automatic trap_event(input logic [CAUSE_WIDTH-1:0] cause, input logic [CSR_WIDTH-1:0] pc,
                            input logic [CSR_WIDTH-1:0] ld, input logic [CSR_WIDTH-1:0] st);
    step();
    trap_i <= {1'b1, cause, pc, ld, st};
  endtask

  task automatic read_at(input logic [CSR_ADDR_WIDTH-1:0] addr, input logic checkpoint);
    step();
    rd_addr_i <= addr;
    rd_en_i   <= checkpoint;
  endtask

  task automatic retire_flags(input logic [FFLAGS_WIDTH-1:0] flags);
    step();
    retire_i.fflags <= flags;
  endtask

  task automatic expect_read(input logic [CSR_ADDR_WIDTH-1:0] addr,
                             input logic [CSR_WIDTH-1:0] expected);
    read_at(addr, 1'b0);
    @(negedge clk);
    check_value("rd_data_o", expected, rd_data_o);
  endtask

  task automatic expect_flags(input logic violation, input logic pending);
    step();
    @(negedge clk);
    check_value("atomic_violation_o", CSR_WIDTH'(violation), CSR_WIDTH'(atomic_violation_o));
    check_value("interrupt_pending_o", CSR_WIDTH'(pending), CSR_WIDTH'(interrupt_pending_o));
  endtask

  // mapped, read-only and unmapped addresses
  function automatic logic [CSR_ADDR_WIDTH-1:0] random_addr();
    logic [CSR_ADDR_WIDTH-1:0] table_addr [14];
    table_addr = '{ADDR_FFLAGS, ADDR_FRM, ADDR_FCSR, ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC,
                   ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP, ADDR_MINSTRET, ADDR_MHARTID,
                   12'h7C0, 12'h123};
    return table_addr[$unsigned($random(seed)) % 14];
  endfunction

  task automatic random_op();
    logic [CSR_WIDTH-1:0] data;
    logic [31:0]          pick;
    data = {$random(seed), $random(seed)};
    pick = $random(seed);
    case (pick % 6)
      0:       write_commit(random_addr(), data);
      1:       write_flush_commit(random_addr(), data);
      2:       trap_event(data[4:0], data, ~data, {data[31:0], data[63:32]});
      3:       read_at(random_addr(), pick[8]);
      4:       flush_only();
      default: commit_only(pick[9]);
    endcase
  endtask

  initial
  begin
    automatic logic [CAUSE_WIDTH-1:0] causes [7] = '{5'd0, 5'd1, 5'd4, 5'd5, 5'd6, 5'd7, 5'd3};
    logic [CSR_WIDTH-1:0] pc;
    logic [CSR_WIDTH-1:0] ld;
    logic [CSR_WIDTH-1:0] st;
    logic [CSR_WIDTH-1:0] exp_tval;

    reset     = 1'b1;
    flush_i   = 1'b0;
    commit_i  = 1'b0;
    wr_en_i   = 1'b0;
    rd_en_i   = 1'b0;
    wr_req_i  = '0;
    rd_addr_i = '0;
    trap_i    = '0;
    retire_i  = '0;
    hartid_i  = {$random(seed), $random(seed)};
    exp_tval  = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // masked and aligned writes
    write_commit(ADDR_MSTATUS, '1);
    expect_read(ADDR_MSTATUS, MSTATUS_RESET | MSTATUS_WRITE_MASK);
    write_commit(ADDR_MSTATUS, '0);
    expect_read(ADDR_MSTATUS, MSTATUS_RESET);
    write_commit(ADDR_MIE, '1);
    expect_read(ADDR_MIE, MIE_MASK);
    write_commit(ADDR_MIP, '1);
    expect_read(ADDR_MIP, MIP_MASK);
    write_commit(ADDR_MTVEC, 64'h8000_0107);
    expect_read(ADDR_MTVEC, 64'h8000_0105);
    write_commit(ADDR_MEPC, 64'h4321);
    expect_read(ADDR_MEPC, 64'h4320);
    write_commit(ADDR_MINSTRET, '0);
    read_at(ADDR_MINSTRET, 1'b0);

    // a flushed write never lands
    write_flush_commit(ADDR_MTVEC, 64'hDEAD_0000);
    expect_read(ADDR_MTVEC, 64'h8000_0105);
    write_flush_commit(ADDR_MIE, '0);
    expect_read(ADDR_MIE, MIE_MASK);

    // traps, the last cause is unlisted and keeps mtval
    for (int i = 0; i < 7; i++)
    begin
      pc = 64'h8000_1000 + 64'(i * 16);
      ld = 64'h0001_0000 + 64'(i * 8);
      st = 64'h0002_0000 + 64'(i * 8);
      trap_event(causes[i], pc, ld, st);
      case (causes[i])
        5'd0, 5'd1: exp_tval = pc;
        5'd4, 5'd5: exp_tval = ld;
        5'd6, 5'd7: exp_tval = st;
        default:    exp_tval = exp_tval;
      endcase
      expect_read(ADDR_MTVAL, exp_tval);
      expect_read(ADDR_MCAUSE, 64'(causes[i]));
      check_value("epc_o", pc, epc_o);
    end
    read_at(ADDR_MINSTRET, 1'b0);

    // floating-point flags and rounding mode
    write_commit(ADDR_FCSR, '0);
    retire_flags(5'b00001);
    retire_flags(5'b00100);
    expect_read(ADDR_FFLAGS, 64'h05);
    write_commit(ADDR_FRM, 64'h5);
    expect_read(ADDR_FRM, 64'h5);
    check_value("frm_o", 64'h5, frm_o);
    expect_read(ADDR_FCSR, 64'hA5);
    write_commit(ADDR_FFLAGS, 64'h12);
    expect_read(ADDR_FCSR, 64'hB2);

    // read checkpoint against a committed write to the same CSR
    read_at(ADDR_MEPC, 1'b1);
    stage_write(ADDR_MEPC, 64'h9000);
    commit_only(1'b1);
    expect_flags(1'b1, 1'b0);
    flush_only();
    expect_flags(1'b0, 1'b0);
    read_at(ADDR_MCAUSE, 1'b1);
    expect_flags(1'b0, 1'b0);
    expect_flags(1'b0, 1'b0);
    flush_only();

    // interrupt pending, hart id and unmapped reads
    write_commit(ADDR_MSTATUS, 64'h8);
    expect_flags(1'b0, 1'b1);
    write_commit(ADDR_MIP, '0);
    expect_flags(1'b0, 1'b0);
    write_commit(ADDR_MIP, '1);
    expect_flags(1'b0, 1'b1);
    write_commit(ADDR_MSTATUS, '0);
    expect_flags(1'b0, 1'b0);
    expect_read(ADDR_MHARTID, hartid_i);
    expect_read(12'h7C0, '0);

    fp_random = 1'b1;
    repeat (RANDOM_OPS) random_op();
    fp_random = 1'b0;
    step();
    step();
    @(negedge clk);

    $display("checks run: %0d, mismatches: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("checks run: %0d, mismatches: %0d", check_count, error_count);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
